// File: bench/video_format_properties.sv
`timescale 1ns/10ps

module video_format_properties (
	input logic        clk50m_bufg,
	input logic        reset,
	input logic [3:0]  sw,
	input logic        progdone,
	input logic        progen,
	input logic        progdata,
	input logic        busy,
	input logic        hsync,
	input logic        vsync,
	input logic        de,
	input logic [10:0] hcount,
	input logic [10:0] vcount
);

	int fail_count = 0;  // Read by the testbench

	logic [3:0] fmt_code;  // Switch code taken when busy rises
	logic [3:0] cur_code;
	logic       busy_q;
	int         h_live, h_tot, h_sw, v_live, v_tot, v_sw;
	logic       neg_pol;
	logic [7:0] exp_m, exp_d;
	logic [9:0] word_d, word_m;
	logic       exp_bit;
	int         bit_cnt;  // progen cycles seen in this request
	logic       hs_act, vs_act, hs_act_q, vs_act_q, de_q;
	logic       hs_edge, hs_fall, vs_edge, vs_fall, de_fall;
	logic       have_h, have_v;  // A reference edge exists since busy
	int         h_gap, hs_len, de_len, vs_len, v_lines, de_lines;
	logic [10:0] hcount_d1, hcount_d2;  // Counters lined up with de
	logic [10:0] vcount_d1, vcount_d2;

	////////////////////////////////////////////////////////////////////////////
	// Expected values per switch code
	////////////////////////////////////////////////////////////////////////////
	assign cur_code = (busy && !busy_q) ? sw : fmt_code;

	always_comb begin
		case (cur_code)
			4'b0000: begin  // VGA
				h_live  = 640;
				h_tot   = 640 + 16 + 96 + 48;
				h_sw    = 96;
				v_live  = 480;
				v_tot   = 480 + 11 + 2 + 31;
				v_sw    = 2;
				neg_pol = 1'b1;
				exp_m   = 8'd1;
				exp_d   = 8'd3;
			end
			4'b0001: begin  // SVGA
				h_live  = 800;
				h_tot   = 800 + 40 + 128 + 88;
				h_sw    = 128;
				v_live  = 600;
				v_tot   = 600 + 1 + 4 + 23;
				v_sw    = 4;
				neg_pol = 1'b0;
				exp_m   = 8'd3;
				exp_d   = 8'd4;
			end
			4'b0011: begin  // XGA
				h_live  = 1024;
				h_tot   = 1024 + 24 + 136 + 160;
				h_sw    = 136;
				v_live  = 768;
				v_tot   = 768 + 3 + 6 + 29;
				v_sw    = 6;
				neg_pol = 1'b1;
				exp_m   = 8'd12;
				exp_d   = 8'd9;
			end
			4'b1000: begin  // SXGA
				h_live  = 1280;
				h_tot   = 1280 + 48 + 112 + 248;
				h_sw    = 112;
				v_live  = 1024;
				v_tot   = 1024 + 1 + 3 + 38;
				v_sw    = 3;
				neg_pol = 1'b0;
				exp_m   = 8'd53;
				exp_d   = 8'd24;
			end
			4'b1001: begin  // Camera
				h_live  = 1280;
				h_tot   = 1280 + 110 + 39 + 220;
				h_sw    = 39;
				v_live  = 720;
				v_tot   = 720 + 4 + 4 + 22;
				v_sw    = 4;
				neg_pol = 1'b0;
				exp_m   = 8'd134;
				exp_d   = 8'd90;
			end
			default: begin  // HD720, also every unlisted code
				h_live  = 1280;
				h_tot   = 1280 + 110 + 40 + 220;
				h_sw    = 40;
				v_live  = 720;
				v_tot   = 720 + 5 + 5 + 20;
				v_sw    = 5;
				neg_pol = 1'b0;
				exp_m   = 8'd247;
				exp_d   = 8'd166;
			end
		endcase
		word_d = {exp_d, 2'b01};  // LOAD_D prefix first on the wire
		word_m = {exp_m, 2'b11};
		if (bit_cnt < 10)
			exp_bit = word_d[bit_cnt];
		else if (bit_cnt < 20)
			exp_bit = word_m[bit_cnt - 10];
		else
			exp_bit = 1'b0;  // Go command
	end

	assign hs_act  = hsync ^ neg_pol;
	assign vs_act  = vsync ^ neg_pol;
	assign hs_edge = hs_act && !hs_act_q;
	assign hs_fall = !hs_act && hs_act_q;
	assign vs_edge = vs_act && !vs_act_q;
	assign vs_fall = !vs_act && vs_act_q;
	assign de_fall = !de && de_q;

	////////////////////////////////////////////////////////////////////////////
	// Measurement counters
	////////////////////////////////////////////////////////////////////////////
	always @(posedge clk50m_bufg) begin
		if (reset) begin
			busy_q    <= 1'b0;
			fmt_code  <= 4'b0000;
			bit_cnt   <= 0;
			hs_act_q  <= 1'b0;
			vs_act_q  <= 1'b0;
			de_q      <= 1'b0;
			have_h    <= 1'b0;
			have_v    <= 1'b0;
			h_gap     <= 0;
			hs_len    <= 0;
			de_len    <= 0;
			vs_len    <= 0;
			v_lines   <= 0;
			de_lines  <= 0;
			hcount_d1 <= '0;
			hcount_d2 <= '0;
			vcount_d1 <= '0;
			vcount_d2 <= '0;
		end else begin
			busy_q <= busy;
			if (busy && !busy_q)
				fmt_code <= sw;
			if (!busy)
				bit_cnt <= 0;
			else if (progen)
				bit_cnt <= bit_cnt + 1;
			hs_act_q  <= hs_act;
			vs_act_q  <= vs_act;
			de_q      <= de;
			hcount_d1 <= hcount;  // Two cycle output latency
			hcount_d2 <= hcount_d1;
			vcount_d1 <= vcount;
			vcount_d2 <= vcount_d1;
			hs_len   <= hs_act ? hs_len + 1 : 0;
			de_len   <= de ? de_len + 1 : 0;
			vs_len   <= !vs_act ? 0 : (hs_edge ? vs_len + 1 : vs_len);  // Lines in pulse
			if (busy) begin
				have_h <= 1'b0;
				have_v <= 1'b0;
			end else begin
				if (hs_edge) begin
					have_h <= 1'b1;
					h_gap  <= 1;
				end else
					h_gap <= h_gap + 1;
				if (vs_edge) begin
					have_v   <= 1'b1;
					v_lines  <= 0;
					de_lines <= 0;
				end else begin
					if (hs_edge) v_lines <= v_lines + 1;
					if (de_fall) de_lines <= de_lines + 1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Programming stream and busy
	////////////////////////////////////////////////////////////////////////////
	a_stream_bit: assert property (@(posedge clk50m_bufg) disable iff (reset)
		busy && progen |-> progdata == exp_bit)
		else begin
			$error("error stream_bit %0d expected %0d actual %0d",
				bit_cnt, exp_bit, progdata);
			fail_count = fail_count + 1;
		end

	a_stream_len: assert property (@(posedge clk50m_bufg) disable iff (reset)
		$fell(busy) |-> bit_cnt == 21)
		else begin
			$error("error stream_len expected 21 actual %0d", bit_cnt);
			fail_count = fail_count + 1;
		end

	a_idle_progen: assert property (@(posedge clk50m_bufg) disable iff (reset)
		!busy |-> !progen)
		else begin
			$error("progen was high while the serializer was not busy");
			fail_count = fail_count + 1;
		end

	a_busy_fall: assert property (@(posedge clk50m_bufg) disable iff (reset)
		$fell(busy) |-> $past(progdone))
		else begin
			$error("busy fell without progdone in the cycle before");
			fail_count = fail_count + 1;
		end

	a_busy_hold: assert property (@(posedge clk50m_bufg) disable iff (reset)
		busy && !progdone |=> busy)
		else begin
			$error("busy fell before progdone was seen");
			fail_count = fail_count + 1;
		end

	a_de_quiet: assert property (@(posedge clk50m_bufg) disable iff (reset)
		busy || $past(busy) |-> !de)
		else begin
			$error("de was high while the pixel clock was being programmed");
			fail_count = fail_count + 1;
		end

	////////////////////////////////////////////////////////////////////////////
	// Display timing
	////////////////////////////////////////////////////////////////////////////
	a_h_period: assert property (@(posedge clk50m_bufg) disable iff (reset)
		!busy && have_h && hs_edge |-> h_gap == h_tot)
		else begin
			$error("error h_period expected %0d actual %0d", h_tot, h_gap);
			fail_count = fail_count + 1;
		end

	a_h_width: assert property (@(posedge clk50m_bufg) disable iff (reset)
		!busy && hs_fall |-> hs_len == h_sw)
		else begin
			$error("error h_width expected %0d actual %0d", h_sw, hs_len);
			fail_count = fail_count + 1;
		end

	a_de_width: assert property (@(posedge clk50m_bufg) disable iff (reset)
		!busy && de_fall |-> de_len == h_live)
		else begin
			$error("error de_width expected %0d actual %0d", h_live, de_len);
			fail_count = fail_count + 1;
		end

	a_de_lines: assert property (@(posedge clk50m_bufg) disable iff (reset)
		!busy && have_v && vs_edge |-> de_lines == v_live)
		else begin
			$error("error de_lines expected %0d actual %0d", v_live, de_lines);
			fail_count = fail_count + 1;
		end

	a_v_frame: assert property (@(posedge clk50m_bufg) disable iff (reset)
		!busy && have_v && vs_edge |-> v_lines == v_tot)
		else begin
			$error("error v_frame expected %0d actual %0d", v_tot, v_lines);
			fail_count = fail_count + 1;
		end

	a_v_width: assert property (@(posedge clk50m_bufg) disable iff (reset)
		!busy && vs_fall |-> vs_len == v_sw)
		else begin
			$error("error v_width expected %0d actual %0d", v_sw, vs_len);
			fail_count = fail_count + 1;
		end

	// First blank pixel of a line sits at the live width
	a_hcount: assert property (@(posedge clk50m_bufg) disable iff (reset)
		!busy && de_fall |-> hcount_d2 == h_live)
		else begin
			$error("error hcount expected %0d actual %0d", h_live, hcount_d2);
			fail_count = fail_count + 1;
		end

	// Live line index, counted from the frame start
	a_vcount: assert property (@(posedge clk50m_bufg) disable iff (reset)
		!busy && have_v && de_fall |-> vcount_d2 == de_lines)
		else begin
			$error("error vcount expected %0d actual %0d", de_lines, vcount_d2);
			fail_count = fail_count + 1;
		end

endmodule

bind video_format_top video_format_properties props_inst (
	.clk50m_bufg (clk50m_bufg),
	.reset       (reset),
	.sw          (sw),
	.progdone    (progdone),
	.progen      (progen),
	.progdata    (progdata),
	.busy        (busy),
	.hsync       (hsync),
	.vsync       (vsync),
	.de          (de),
	.hcount      (hcount),
	.vcount      (vcount)
);

// File: bench/video_format_tb.sv
`timescale 1ns/10ps

module video_format_tb;

	////////////////////////////////////////////////////////////////////////////
	// Run length, frames in clock cycles
	////////////////////////////////////////////////////////////////////////////
	localparam longint VGA_FRAME  = 800 * 524;
	localparam longint SVGA_FRAME = 1056 * 628;
	localparam longint HD_LINE    = 1650;
	localparam longint PROG_LEN   = 18 + 23 + 8 + 4;  // Debounce, stream, progdone
	localparam longint RUN_CYCLES = 16 + 4 * PROG_LEN + 3 * VGA_FRAME
		+ 2 * SVGA_FRAME + 3 * HD_LINE + 3 * 1056;
	localparam longint LIMIT_NS   = RUN_CYCLES * 12 / 10 * 20;  // Plus 20%

	logic        clk50m_bufg = 1'b0;
	logic        reset;
	logic [3:0]  sw;
	logic        progdone;
	logic        progen;
	logic        progdata;
	logic        busy;
	logic        hsync;
	logic        vsync;
	logic        de;
	logic [10:0] hcount;
	logic [10:0] vcount;
	logic [2:0]  pen_hist;   // Last progen samples, newest in bit 0
	int          done_wait;  // Cycles until progdone rises

	always #10 clk50m_bufg = ~clk50m_bufg;

	video_format_top video_format_top_inst (
		.clk50m_bufg (clk50m_bufg),
		.reset       (reset),
		.sw          (sw),
		.progdone    (progdone),
		.progen      (progen),
		.progdata    (progdata),
		.busy        (busy),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de),
		.hcount      (hcount),
		.vcount      (vcount)
	);

	// Clock synthesizer model, answers the single go cycle
	always @(posedge clk50m_bufg) begin
		pen_hist <= {pen_hist[1:0], progen};
		if (pen_hist[1:0] == 2'b10 && !progen && !pen_hist[2])
			done_wait <= 3;
		else if (done_wait > 0) begin
			done_wait <= done_wait - 1;
			if (done_wait == 1)
				progdone <= 1'b1;
		end
		if (progdone && !busy)
			progdone <= 1'b0;
	end

	// First assertion failure ends the run
	always @(posedge clk50m_bufg) begin
		if (video_format_top_inst.props_inst.fail_count != 0) begin
			$display("tests failed");
			$fatal(1, "an assertion on the DUT outputs failed");
		end
	end

	initial begin
		#(LIMIT_NS);
		$display("tests failed");
		$fatal(1, "run did not finish in time");
	end

	task automatic wait_programmed();
		@(posedge busy);
		@(negedge busy);
	endtask

	task automatic wait_vsync(input int n, input logic neg);
		repeat (n) begin
			if (neg)
				@(negedge vsync);
			else
				@(posedge vsync);
		end
	endtask

	task automatic select_mode(input logic [3:0] code);
		@(posedge clk50m_bufg);
		sw <= code;
		wait_programmed();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////
	initial begin
		reset     <= 1'b1;
		sw        <= 4'b0000;  // VGA
		progdone  <= 1'b0;
		pen_hist  <= 3'b000;
		done_wait <= 0;
		repeat (16) @(posedge clk50m_bufg);
		reset <= 1'b0;

		wait_programmed();
		wait_vsync(3, 1'b1);   // Two whole VGA frames

		select_mode(4'b0001);  // SVGA
		wait_vsync(2, 1'b0);

		select_mode(4'b0111);  // Unlisted, runs as 720p
		repeat (3) @(posedge hsync);

		select_mode(4'b0001);
		repeat (3) @(posedge hsync);

		repeat (4) @(posedge clk50m_bufg);
		if (video_format_top_inst.props_inst.fail_count == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			$display("tests failed");
			$fatal(1, "an assertion on the DUT outputs failed");
		end
	end

endmodule

// File: run.sh
#!/bin/sh
# Build and run with Verilator, pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f verilog.f \
	--top-module video_format_tb -Mdir obj_dir -o video_format_sim \
	> build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/video_format_sim > sim.log 2>&1

grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// File: source/dcm_prog_serializer.sv
`timescale 1ns/10ps

// DCM_CLKGEN programming port
//   LOAD_D word, gap, LOAD_M word, gap, go bit, then wait for progdone
module dcm_prog_serializer (
	input  logic clk50m_bufg,
	input  logic reset,
	input  logic progdone,
	prog_if.ser  pbus,
	output logic progen,
	output logic progdata
);

	logic [video_pkg::PHASE_W-1:0] phase;    // Position in the 23 cycle stream
	logic                          sending;
	logic                          waiting;  // Go sent, progdone not seen yet
	logic [video_pkg::WORD_W-1:0]  shreg;    // Bit 0 is on the wire
	logic                          gap;

	assign gap      = (phase == video_pkg::PH_IDLE_D) || (phase == video_pkg::PH_IDLE_M);
	assign progen   = sending && !gap;
	assign progdata = progen && shreg[0];  // Zero during the go bit

	always_ff @(posedge clk50m_bufg) begin
		if (reset) begin
			sending   <= 1'b0;
			waiting   <= 1'b0;
			phase     <= '0;
			pbus.busy <= 1'b0;
		end else if (sending) begin
			phase <= phase + video_pkg::PH_ONE;
			if (phase == video_pkg::PH_GO) begin
				sending <= 1'b0;
				waiting <= 1'b1;
			end
		end else if (waiting) begin
			if (progdone) begin
				waiting   <= 1'b0;
				pbus.busy <= 1'b0;  // Drops the cycle after progdone
			end
		end else if (pbus.go) begin
			sending   <= 1'b1;
			phase     <= '0;
			pbus.busy <= 1'b1;
		end
	end

	// Reloads happen in the gap cycles
	always_ff @(posedge clk50m_bufg) begin
		if (pbus.go && !pbus.busy)
			shreg <= {pbus.d, video_pkg::CMD_LOAD_D};
		else if (phase == video_pkg::PH_IDLE_D)
			shreg <= {pbus.m, video_pkg::CMD_LOAD_M};
		else if (phase == video_pkg::PH_IDLE_M)
			shreg <= '0;  // Go command carries a zero
		else
			shreg <= shreg >> 1;
	end

endmodule

// File: source/format_control.sv
`timescale 1ns/10ps

module format_control (
	input  logic                     clk50m_bufg,
	input  logic                     reset,
	input  video_pkg::video_format_e sw_settled,
	timing_if.ctrl                   tbus,
	prog_if.ctrl                     pbus
);

	video_pkg::ctrl_state_e   state;
	video_pkg::video_format_e cur_fmt;  // Format being programmed or shown
	video_pkg::timing_t       tim;
	video_pkg::clock_t        md;

	////////////////////////////////////////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (reset) begin
			state        <= video_pkg::ST_IDLE;
			cur_fmt      <= video_pkg::FMT_VGA;
			pbus.go      <= 1'b0;
			tbus.restart <= 1'b1;
		end else begin
			pbus.go <= 1'b0;  // Single cycle strobe
			case (state)
				// First cycle out of reset, program whatever is current
				video_pkg::ST_IDLE: begin
					pbus.go      <= 1'b1;
					tbus.restart <= 1'b1;
					state        <= video_pkg::ST_PROG;
				end

				video_pkg::ST_PROG: begin
					state <= video_pkg::ST_WAIT_DONE;  // busy is up from here
				end

				video_pkg::ST_WAIT_DONE: begin
					if (!pbus.busy) begin
						tbus.restart <= 1'b0;  // Clock is locked, run timing
						state        <= video_pkg::ST_RUN;
					end
				end

				video_pkg::ST_RUN: begin
					// New mode settled, reprogram and hold timing
					if (sw_settled != cur_fmt) begin
						cur_fmt      <= sw_settled;
						pbus.go      <= 1'b1;
						tbus.restart <= 1'b1;
						state        <= video_pkg::ST_PROG;
					end
				end

				default: state <= video_pkg::ST_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Table lookup for the current format
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		tim = video_pkg::format_timing(cur_fmt);
		md  = video_pkg::format_clock(cur_fmt);

		pbus.m = md.m_minus1;
		pbus.d = md.d_minus1;

		// Each edge is the previous one plus the next interval
		tbus.hs_blank = tim.h_live - video_pkg::CNT_ONE;
		tbus.hs_sync  = tbus.hs_blank + tim.h_front;
		tbus.he_sync  = tbus.hs_sync + tim.h_sync;
		tbus.he_blank = tbus.he_sync + tim.h_back;   // Line total minus one
		tbus.vs_blank = tim.v_live - video_pkg::CNT_ONE;
		tbus.vs_sync  = tbus.vs_blank + tim.v_front;
		tbus.ve_sync  = tbus.vs_sync + tim.v_sync;
		tbus.ve_blank = tbus.ve_sync + tim.v_back;   // Frame total minus one
		tbus.polarity = tim.neg_pol;
	end

endmodule

// File: source/switch_debouncer.sv
`timescale 1ns/10ps

module switch_debouncer (
	input  logic                          clk50m_bufg,
	input  logic                          reset,
	input  logic [video_pkg::SW_W-1:0]    sw,          // Asynchronous switches
	output video_pkg::video_format_e      sw_settled
);

	logic [video_pkg::SW_W-1:0] sw_meta;
	logic [video_pkg::SW_W-1:0] sw_sync;
	logic [video_pkg::DB_W-1:0] db_cnt;   // Cycles sw_sync has held its value

	// Two flop synchronizer
	always_ff @(posedge clk50m_bufg) begin
		sw_meta <= sw;
		sw_sync <= sw_meta;
	end

	always_ff @(posedge clk50m_bufg) begin
		if (reset) begin
			db_cnt     <= '0;
			sw_settled <= video_pkg::FMT_VGA;
		end else begin
			if (sw_meta != sw_sync)
				db_cnt <= video_pkg::DB_ONE;  // New value enters sw_sync now
			else if (db_cnt != video_pkg::DB_DONE)
				db_cnt <= db_cnt + video_pkg::DB_ONE;  // Saturates at DONE

			// Held long enough, take it
			if (db_cnt == video_pkg::DB_DONE)
				sw_settled <= video_pkg::map_switch(sw_sync);
		end
	end

endmodule

// File: source/video_format_top.sv
`timescale 1ns/10ps

module video_format_top (
	input  logic                          clk50m_bufg,
	input  logic                          reset,
	input  logic [video_pkg::SW_W-1:0]    sw,        // Mode switches
	input  logic                          progdone,  // From the clock synthesizer
	output logic                          progen,
	output logic                          progdata,
	output logic                          busy,      // Low again once timing restarts
	output logic                          hsync,
	output logic                          vsync,
	output logic                          de,
	output logic [video_pkg::COUNT_W-1:0] hcount,
	output logic [video_pkg::COUNT_W-1:0] vcount
);

	video_pkg::video_format_e sw_settled;

	timing_if timing_bus ();
	prog_if   prog_bus ();

	assign busy = prog_bus.busy;

	switch_debouncer switch_debouncer_inst (
		.clk50m_bufg (clk50m_bufg),
		.reset       (reset),
		.sw          (sw),
		.sw_settled  (sw_settled)
	);

	format_control format_control_inst (
		.clk50m_bufg (clk50m_bufg),
		.reset       (reset),
		.sw_settled  (sw_settled),
		.tbus        (timing_bus),
		.pbus        (prog_bus)
	);

	dcm_prog_serializer dcm_prog_serializer_inst (
		.clk50m_bufg (clk50m_bufg),
		.reset       (reset),
		.progdone    (progdone),
		.pbus        (prog_bus),
		.progen      (progen),
		.progdata    (progdata)
	);

	video_timing_gen video_timing_gen_inst (
		.clk50m_bufg (clk50m_bufg),
		.reset       (reset),
		.tbus        (timing_bus),
		.hcount      (hcount),
		.vcount      (vcount),
		.hsync       (hsync),
		.vsync       (vsync),
		.de          (de)
	);

endmodule

// File: source/video_if.sv
`timescale 1ns/10ps

// Thresholds and control from format control to the timing generator
interface timing_if;
	logic [video_pkg::COUNT_W-1:0] hs_blank;  // Last live pixel
	logic [video_pkg::COUNT_W-1:0] hs_sync;
	logic [video_pkg::COUNT_W-1:0] he_sync;
	logic [video_pkg::COUNT_W-1:0] he_blank;  // Last pixel of the line
	logic [video_pkg::COUNT_W-1:0] vs_blank;
	logic [video_pkg::COUNT_W-1:0] vs_sync;
	logic [video_pkg::COUNT_W-1:0] ve_sync;
	logic [video_pkg::COUNT_W-1:0] ve_blank;
	logic                          polarity;  // 1 = negative
	logic                          restart;   // Level, holds counters at zero

	modport ctrl (output hs_blank, hs_sync, he_sync, he_blank,
		vs_blank, vs_sync, ve_sync, ve_blank, polarity, restart);
	modport gen (input hs_blank, hs_sync, he_sync, he_blank,
		vs_blank, vs_sync, ve_sync, ve_blank, polarity, restart);
endinterface

// Clock programming request
interface prog_if;
	logic [video_pkg::MD_W-1:0] m;     // M minus one
	logic [video_pkg::MD_W-1:0] d;     // D minus one
	logic                       go;    // One cycle, only while busy is low
	logic                       busy;

	modport ctrl (output m, d, go, input busy);
	modport ser (input m, d, go, output busy);
endinterface

// File: source/video_pkg.sv
package video_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths and counts
	////////////////////////////////////////////////////////////////////////////
	localparam int COUNT_W         = 11;  // Pixel and line counters
	localparam int MD_W            = 8;   // DCM_CLKGEN M and D values
	localparam int SW_W            = 4;   // Mode switches
	localparam int DEBOUNCE_CYCLES = 16;  // Stable cycles before a switch counts
	localparam int DB_W            = $clog2(DEBOUNCE_CYCLES + 1);

	localparam logic [COUNT_W-1:0] CNT_ONE = COUNT_W'(1);
	localparam logic [DB_W-1:0]    DB_ONE  = DB_W'(1);
	localparam logic [DB_W-1:0]    DB_DONE = DB_W'(DEBOUNCE_CYCLES);

	// Serial commands, sent low bit first ahead of the value
	localparam int CMD_W  = 2;
	localparam int WORD_W = CMD_W + MD_W;
	localparam logic [CMD_W-1:0] CMD_LOAD_D = 2'b01;
	localparam logic [CMD_W-1:0] CMD_LOAD_M = 2'b11;

	// Stream phases, phase 0 is the cycle after go
	localparam int PHASE_W = 5;
	localparam logic [PHASE_W-1:0] PH_ONE    = PHASE_W'(1);
	localparam logic [PHASE_W-1:0] PH_IDLE_D = PHASE_W'(WORD_W);          // Gap after D
	localparam logic [PHASE_W-1:0] PH_IDLE_M = PHASE_W'(2 * WORD_W + 1);  // Gap after M
	localparam logic [PHASE_W-1:0] PH_GO     = PHASE_W'(2 * WORD_W + 2);  // Go command

	////////////////////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////////////////////
	// Codes match the switch settings
	typedef enum logic [3:0] {
		FMT_VGA    = 4'b0000,
		FMT_SVGA   = 4'b0001,
		FMT_HD720  = 4'b0010,
		FMT_XGA    = 4'b0011,
		FMT_SXGA   = 4'b1000,
		FMT_CAMERA = 4'b1001
	} video_format_e;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_PROG,
		ST_WAIT_DONE,
		ST_RUN
	} ctrl_state_e;

	// Live, front porch, sync, back porch per axis
	typedef struct packed {
		logic [COUNT_W-1:0] h_live;
		logic [COUNT_W-1:0] h_front;
		logic [COUNT_W-1:0] h_sync;
		logic [COUNT_W-1:0] h_back;
		logic [COUNT_W-1:0] v_live;
		logic [COUNT_W-1:0] v_front;
		logic [COUNT_W-1:0] v_sync;
		logic [COUNT_W-1:0] v_back;
		logic               neg_pol;  // 1 = negative sync
	} timing_t;

	typedef struct packed {
		logic [MD_W-1:0] m_minus1;
		logic [MD_W-1:0] d_minus1;
	} clock_t;

	////////////////////////////////////////////////////////////////////////////
	// Format tables
	////////////////////////////////////////////////////////////////////////////
	localparam timing_t TIM_VGA    = '{11'd640, 11'd16, 11'd96, 11'd48,
		11'd480, 11'd11, 11'd2, 11'd31, 1'b1};
	localparam timing_t TIM_SVGA   = '{11'd800, 11'd40, 11'd128, 11'd88,
		11'd600, 11'd1, 11'd4, 11'd23, 1'b0};
	localparam timing_t TIM_XGA    = '{11'd1024, 11'd24, 11'd136, 11'd160,
		11'd768, 11'd3, 11'd6, 11'd29, 1'b1};
	localparam timing_t TIM_SXGA   = '{11'd1280, 11'd48, 11'd112, 11'd248,
		11'd1024, 11'd1, 11'd3, 11'd38, 1'b0};
	localparam timing_t TIM_HD720  = '{11'd1280, 11'd110, 11'd40, 11'd220,
		11'd720, 11'd5, 11'd5, 11'd20, 1'b0};
	localparam timing_t TIM_CAMERA = '{11'd1280, 11'd110, 11'd39, 11'd220,
		11'd720, 11'd4, 11'd4, 11'd22, 1'b0};

	// M-1 / D-1 for the pixel clock synthesizer
	localparam clock_t CLK_VGA    = '{8'd1, 8'd3};      // 25 MHz
	localparam clock_t CLK_SVGA   = '{8'd3, 8'd4};      // 40 MHz
	localparam clock_t CLK_XGA    = '{8'd12, 8'd9};     // 65 MHz
	localparam clock_t CLK_SXGA   = '{8'd53, 8'd24};    // 108 MHz
	localparam clock_t CLK_CAMERA = '{8'd134, 8'd90};
	localparam clock_t CLK_HD720  = '{8'd247, 8'd166};  // 74.25 MHz

	// Unlisted switch codes fall back to 720p
	function automatic video_format_e map_switch(input logic [SW_W-1:0] sw);
		video_format_e fmt;
		case (sw)
			FMT_VGA, FMT_SVGA, FMT_HD720, FMT_XGA, FMT_SXGA, FMT_CAMERA:
				fmt = video_format_e'(sw);
			default: fmt = FMT_HD720;
		endcase
		return fmt;
	endfunction

	function automatic timing_t format_timing(input video_format_e fmt);
		timing_t tim;
		case (fmt)
			FMT_VGA:    tim = TIM_VGA;
			FMT_SVGA:   tim = TIM_SVGA;
			FMT_XGA:    tim = TIM_XGA;
			FMT_SXGA:   tim = TIM_SXGA;
			FMT_CAMERA: tim = TIM_CAMERA;
			default:    tim = TIM_HD720;
		endcase
		return tim;
	endfunction

	function automatic clock_t format_clock(input video_format_e fmt);
		clock_t md;
		case (fmt)
			FMT_VGA:    md = CLK_VGA;
			FMT_SVGA:   md = CLK_SVGA;
			FMT_XGA:    md = CLK_XGA;
			FMT_SXGA:   md = CLK_SXGA;
			FMT_CAMERA: md = CLK_CAMERA;
			default:    md = CLK_HD720;
		endcase
		return md;
	endfunction

endpackage

// File: source/video_timing_gen.sv
`timescale 1ns/10ps

module video_timing_gen (
	input  logic                          clk50m_bufg,
	input  logic                          reset,
	timing_if.gen                         tbus,
	output logic [video_pkg::COUNT_W-1:0] hcount,  // Undelayed
	output logic [video_pkg::COUNT_W-1:0] vcount,
	output logic                          hsync,
	output logic                          vsync,
	output logic                          de
);

	logic h_wrap;
	logic v_wrap;
	logic h_blank;
	logic v_blank;
	logic h_sync_raw;
	logic v_sync_raw;
	logic hsync_q;
	logic vsync_q;
	logic de_q;

	////////////////////////////////////////////////////////////////////////////
	// Counters
	////////////////////////////////////////////////////////////////////////////
	assign h_wrap = (hcount == tbus.he_blank);
	assign v_wrap = (vcount == tbus.ve_blank);

	always_ff @(posedge clk50m_bufg) begin
		if (reset || tbus.restart) begin
			hcount <= '0;
			vcount <= '0;
		end else if (h_wrap) begin
			hcount <= '0;
			// Line step, frame wrap
			vcount <= v_wrap ? '0 : vcount + video_pkg::CNT_ONE;
		end else begin
			hcount <= hcount + video_pkg::CNT_ONE;
		end
	end

	// Decode against thresholds, sync starts one past hs_sync
	always_comb begin
		h_blank    = hcount > tbus.hs_blank;
		v_blank    = vcount > tbus.vs_blank;
		h_sync_raw = (hcount > tbus.hs_sync) && (hcount <= tbus.he_sync);
		v_sync_raw = (vcount > tbus.vs_sync) && (vcount <= tbus.ve_sync);
	end

	////////////////////////////////////////////////////////////////////////////
	// Two stage output pipe
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (reset || tbus.restart) begin
			// Inactive sync level equals polarity
			hsync_q <= tbus.polarity;
			vsync_q <= tbus.polarity;
			hsync   <= tbus.polarity;
			vsync   <= tbus.polarity;
			de_q    <= 1'b0;
			de      <= 1'b0;
		end else begin
			hsync_q <= h_sync_raw ^ tbus.polarity;
			vsync_q <= v_sync_raw ^ tbus.polarity;
			hsync   <= hsync_q;
			vsync   <= vsync_q;
			de_q    <= !(h_blank || v_blank);  // Live area
			de      <= de_q;
		end
	end

endmodule

// File: verilog.f
source/video_pkg.sv
source/video_if.sv
source/switch_debouncer.sv
source/format_control.sv
source/dcm_prog_serializer.sv
source/video_timing_gen.sv
source/video_format_top.sv
bench/video_format_properties.sv
bench/video_format_tb.sv
